// ==== logic/fb_pkg.sv ====
package fb_pkg;

    // framebuffer size in words, one word per pixel
    localparam int FB_DEPTH = 64;

    // cycles after rst falls at which each reset domain is released
    localparam int MEM_RST_CYCLES = 31;
    localparam int CORE_RST_CYCLES = 62;

    // word address into the framebuffer
    typedef logic [5:0] fb_addr_t;

    // stored pixel, red in [17:12], green in [11:6], blue in [5:0]
    typedef logic [17:0] fb_word_t;

    // reset sequencer count, saturates at all ones
    typedef logic [5:0] rst_cnt_t;

endpackage

// ==== logic/lcd_pkg.sv ====
package lcd_pkg;

    // panel geometry in pixel clocks and lines
    localparam int H_ACTIVE = 8;
    localparam int H_TOTAL = 12;
    localparam int V_ACTIVE = 8;
    localparam int V_TOTAL = 10;

    // sync pulses are active low from start up to end, end excluded
    localparam int H_SYNC_START = 9;
    localparam int H_SYNC_END = 10;
    localparam int V_SYNC_START = 8;
    localparam int V_SYNC_END = 9;

    // entries in the pixel prefetch FIFO
    localparam int FETCH_DEPTH = 4;

    typedef logic [3:0] hcount_t;
    typedef logic [3:0] vcount_t;
    typedef logic [5:0] color_t;

    // number of words held in the prefetch FIFO, 0 to FETCH_DEPTH
    typedef logic [2:0] pix_cnt_t;

    typedef enum logic {WAIT_FILL, SCAN} lcd_state_t;

endpackage

// ==== logic/rst_seq.sv ====
`timescale 1ns/1ps

module rst_seq import fb_pkg::*; (
    input  logic clk245760,
    input  logic rst,
    output logic mem_rst_o,
    output logic core_rst_o
);

    rst_cnt_t cnt;
    rst_cnt_t cnt_nxt;

    // restart on rst, otherwise count up and hold at all ones
    always_comb begin
        if (rst) begin
            cnt_nxt = '0;
        end else if (cnt != '1) begin
            cnt_nxt = cnt + rst_cnt_t'(1);
        end else begin
            cnt_nxt = cnt;
        end
    end

    always_ff @(posedge clk245760) begin
        cnt <= cnt_nxt;
    end

    // memory comes out of reset first, display logic later
    always_ff @(posedge clk245760) begin
        if (rst) begin
            mem_rst_o <= 1'b1;
            core_rst_o <= 1'b1;
        end else begin
            mem_rst_o <= (cnt_nxt < MEM_RST_CYCLES);
            core_rst_o <= (cnt_nxt < CORE_RST_CYCLES);
        end
    end

endmodule

// ==== logic/fb_mem.sv ====
`timescale 1ns/1ps

module fb_mem import fb_pkg::*; (
    input  logic     clk245760,
    input  logic     mem_en_i,
    input  logic     mem_we_i,
    input  fb_addr_t mem_addr_i,
    input  fb_word_t mem_wdata_i,
    output fb_word_t mem_rdata_o
);

    fb_word_t mem [FB_DEPTH];

    // single port, write lands on the enable edge
    always_ff @(posedge clk245760) begin
        if (mem_en_i && mem_we_i) begin
            mem[mem_addr_i] <= mem_wdata_i;
        end
    end

    // read data appears one cycle after the enable
    always_ff @(posedge clk245760) begin
        if (mem_en_i && !mem_we_i) begin
            mem_rdata_o <= mem[mem_addr_i];
        end
    end

endmodule

// ==== logic/fb_arbiter.sv ====
`timescale 1ns/1ps

module fb_arbiter import fb_pkg::*; (
    input  logic     clk245760,
    input  logic     rst,

    input  logic     disp_req_valid_i,
    input  fb_addr_t disp_req_addr_i,
    output logic     disp_req_ready_o,
    output logic     disp_rdata_valid_o,
    output fb_word_t disp_rdata_o,

    input  logic     host_req_valid_i,
    input  logic     host_req_we_i,
    input  fb_addr_t host_req_addr_i,
    input  fb_word_t host_req_wdata_i,
    output logic     host_req_ready_o,
    output logic     host_rdata_valid_o,
    output fb_word_t host_rdata_o,

    output logic     mem_en_o,
    output logic     mem_we_o,
    output fb_addr_t mem_addr_o,
    output fb_word_t mem_wdata_o,
    input  fb_word_t mem_rdata_i
);

    logic run_q;
    logic disp_go;
    logic host_go;
    logic disp_rd_q;
    logic host_rd_q;

    // accept requests only once the memory is out of reset
    always_ff @(posedge clk245760) begin
        if (rst) begin
            run_q <= 1'b0;
        end else begin
            run_q <= 1'b1;
        end
    end

    // display wins every cycle it asks, host takes the idle slots
    assign disp_req_ready_o = run_q;
    assign host_req_ready_o = run_q & ~disp_req_valid_i;

    assign disp_go = disp_req_valid_i & disp_req_ready_o;
    assign host_go = host_req_valid_i & host_req_ready_o;

    // memory command mux, display only ever reads
    assign mem_en_o = disp_go | host_go;
    assign mem_we_o = host_go & host_req_we_i;
    assign mem_addr_o = disp_go ? disp_req_addr_i : host_req_addr_i;
    assign mem_wdata_o = host_req_wdata_i;

    // remember who issued the read, data returns next cycle
    always_ff @(posedge clk245760) begin
        if (rst) begin
            disp_rd_q <= 1'b0;
            host_rd_q <= 1'b0;
        end else begin
            disp_rd_q <= disp_go;
            host_rd_q <= host_go & ~host_req_we_i;
        end
    end

    assign disp_rdata_valid_o = disp_rd_q;
    assign host_rdata_valid_o = host_rd_q;
    assign disp_rdata_o = mem_rdata_i;
    assign host_rdata_o = mem_rdata_i;

endmodule

// ==== logic/fb_fetch.sv ====
`timescale 1ns/1ps

module fb_fetch import fb_pkg::*, lcd_pkg::*; (
    input  logic     clk245760,
    input  logic     rst,

    output logic     req_valid_o,
    output fb_addr_t req_addr_o,
    input  logic     req_ready_i,
    input  logic     rdata_valid_i,
    input  fb_word_t rdata_i,

    input  logic     pix_pop_i,
    output fb_word_t pix_word_o,
    output pix_cnt_t pix_count_o
);

    logic run_q;
    logic req_go;
    fb_addr_t addr_q;
    pix_cnt_t credit_q;
    pix_cnt_t fill_q;
    logic [$clog2(FETCH_DEPTH)-1:0] wr_ptr_q;
    logic [$clog2(FETCH_DEPTH)-1:0] rd_ptr_q;
    fb_word_t fifo [FETCH_DEPTH];

    always_ff @(posedge clk245760) begin
        if (rst) begin
            run_q <= 1'b0;
        end else begin
            run_q <= 1'b1;
        end
    end

    // credit counts stored words plus reads still in flight
    assign req_valid_o = run_q & (credit_q < FETCH_DEPTH);
    assign req_addr_o = addr_q;
    assign req_go = req_valid_o & req_ready_i;

    always_ff @(posedge clk245760) begin
        if (rst) begin
            credit_q <= '0;
        end else if (req_go && !pix_pop_i) begin
            credit_q <= credit_q + pix_cnt_t'(1);
        end else if (!req_go && pix_pop_i) begin
            credit_q <= credit_q - pix_cnt_t'(1);
        end
    end

    // raster order address, wraps at the end of the frame
    always_ff @(posedge clk245760) begin
        if (rst) begin
            addr_q <= '0;
        end else if (req_go) begin
            if (addr_q == fb_addr_t'(FB_DEPTH - 1)) begin
                addr_q <= '0;
            end else begin
                addr_q <= addr_q + fb_addr_t'(1);
            end
        end
    end

    // returns come back in request order
    always_ff @(posedge clk245760) begin
        if (rdata_valid_i) begin
            fifo[wr_ptr_q] <= rdata_i;
        end
    end

    always_ff @(posedge clk245760) begin
        if (rst) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            fill_q <= '0;
        end else begin
            if (rdata_valid_i) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pix_pop_i) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            if (rdata_valid_i && !pix_pop_i) begin
                fill_q <= fill_q + pix_cnt_t'(1);
            end else if (!rdata_valid_i && pix_pop_i) begin
                fill_q <= fill_q - pix_cnt_t'(1);
            end
        end
    end

    assign pix_word_o = fifo[rd_ptr_q];
    assign pix_count_o = fill_q;

endmodule

// ==== logic/lcd_timing.sv ====
`timescale 1ns/1ps

module lcd_timing import fb_pkg::*, lcd_pkg::*; (
    input  logic     clk245760,
    input  logic     rst,

    input  pix_cnt_t pix_count_i,
    input  fb_word_t pix_word_i,
    output logic     pix_pop_o,

    output color_t   lcd_r_o,
    output color_t   lcd_g_o,
    output color_t   lcd_b_o,
    output logic     lcd_de_o,
    output logic     lcd_hsync_o,
    output logic     lcd_vsync_o,
    output logic     underrun_o
);

    lcd_state_t state_q;
    hcount_t h_q;
    vcount_t v_q;
    logic active;
    logic starved;

    // hold off until the prefetch FIFO is full
    always_ff @(posedge clk245760) begin
        if (rst) begin
            state_q <= WAIT_FILL;
        end else if (state_q == WAIT_FILL && pix_count_i == pix_cnt_t'(FETCH_DEPTH)) begin
            state_q <= SCAN;
        end
    end

    // raster counters, scanning starts at the top-left pixel
    always_ff @(posedge clk245760) begin
        if (rst) begin
            h_q <= '0;
            v_q <= '0;
        end else if (state_q == SCAN) begin
            if (h_q == hcount_t'(H_TOTAL - 1)) begin
                h_q <= '0;
                if (v_q == vcount_t'(V_TOTAL - 1)) begin
                    v_q <= '0;
                end else begin
                    v_q <= v_q + vcount_t'(1);
                end
            end else begin
                h_q <= h_q + hcount_t'(1);
            end
        end
    end

    assign active = (state_q == SCAN) && (h_q < H_ACTIVE) && (v_q < V_ACTIVE);
    assign starved = active && (pix_count_i == '0);

    // one word per active cycle, never from an empty FIFO
    assign pix_pop_o = active && !starved;

    always_ff @(posedge clk245760) begin
        if (rst) begin
            lcd_de_o <= 1'b0;
            lcd_hsync_o <= 1'b1;
            lcd_vsync_o <= 1'b1;
        end else begin
            lcd_de_o <= active;
            lcd_hsync_o <= !((state_q == SCAN) && (h_q >= H_SYNC_START) && (h_q < H_SYNC_END));
            lcd_vsync_o <= !((state_q == SCAN) && (v_q >= V_SYNC_START) && (v_q < V_SYNC_END));
        end
    end

    // pixel goes out black when the FIFO ran dry
    always_ff @(posedge clk245760) begin
        if (pix_pop_o) begin
            lcd_r_o <= pix_word_i[17:12];
            lcd_g_o <= pix_word_i[11:6];
            lcd_b_o <= pix_word_i[5:0];
        end else begin
            lcd_r_o <= '0;
            lcd_g_o <= '0;
            lcd_b_o <= '0;
        end
    end

    // sticky until reset
    always_ff @(posedge clk245760) begin
        if (rst) begin
            underrun_o <= 1'b0;
        end else if (starved) begin
            underrun_o <= 1'b1;
        end
    end

endmodule

// ==== logic/fb_display_top.sv ====
`timescale 1ns/1ps

module fb_display_top import fb_pkg::*, lcd_pkg::*; (
    input  logic     clk245760,
    input  logic     rst,

    input  logic     host_req_valid_i,
    input  logic     host_req_we_i,
    input  fb_addr_t host_req_addr_i,
    input  fb_word_t host_req_wdata_i,
    output logic     host_req_ready_o,
    output logic     host_rdata_valid_o,
    output fb_word_t host_rdata_o,

    output color_t   lcd_r_o,
    output color_t   lcd_g_o,
    output color_t   lcd_b_o,
    output logic     lcd_de_o,
    output logic     lcd_hsync_o,
    output logic     lcd_vsync_o,
    output logic     underrun_o
);

    logic mem_rst;
    logic core_rst;

    logic disp_req_valid;
    fb_addr_t disp_req_addr;
    logic disp_req_ready;
    logic disp_rdata_valid;
    fb_word_t disp_rdata;

    logic mem_en;
    logic mem_we;
    fb_addr_t mem_addr;
    fb_word_t mem_wdata;
    fb_word_t mem_rdata;

    logic pix_pop;
    fb_word_t pix_word;
    pix_cnt_t pix_count;

    rst_seq i_rst_seq (
        .clk245760  (clk245760),
        .rst        (rst),
        .mem_rst_o  (mem_rst),
        .core_rst_o (core_rst)
    );

    // on-chip stand-in for the external DRAM
    fb_mem i_fb_mem (
        .clk245760   (clk245760),
        .mem_en_i    (mem_en),
        .mem_we_i    (mem_we),
        .mem_addr_i  (mem_addr),
        .mem_wdata_i (mem_wdata),
        .mem_rdata_o (mem_rdata)
    );

    fb_arbiter i_fb_arbiter (
        .clk245760          (clk245760),
        .rst                (mem_rst),
        .disp_req_valid_i   (disp_req_valid),
        .disp_req_addr_i    (disp_req_addr),
        .disp_req_ready_o   (disp_req_ready),
        .disp_rdata_valid_o (disp_rdata_valid),
        .disp_rdata_o       (disp_rdata),
        .host_req_valid_i   (host_req_valid_i),
        .host_req_we_i      (host_req_we_i),
        .host_req_addr_i    (host_req_addr_i),
        .host_req_wdata_i   (host_req_wdata_i),
        .host_req_ready_o   (host_req_ready_o),
        .host_rdata_valid_o (host_rdata_valid_o),
        .host_rdata_o       (host_rdata_o),
        .mem_en_o           (mem_en),
        .mem_we_o           (mem_we),
        .mem_addr_o         (mem_addr),
        .mem_wdata_o        (mem_wdata),
        .mem_rdata_i        (mem_rdata)
    );

    fb_fetch i_fb_fetch (
        .clk245760     (clk245760),
        .rst           (core_rst),
        .req_valid_o   (disp_req_valid),
        .req_addr_o    (disp_req_addr),
        .req_ready_i   (disp_req_ready),
        .rdata_valid_i (disp_rdata_valid),
        .rdata_i       (disp_rdata),
        .pix_pop_i     (pix_pop),
        .pix_word_o    (pix_word),
        .pix_count_o   (pix_count)
    );

    lcd_timing i_lcd_timing (
        .clk245760   (clk245760),
        .rst         (core_rst),
        .pix_count_i (pix_count),
        .pix_word_i  (pix_word),
        .pix_pop_o   (pix_pop),
        .lcd_r_o     (lcd_r_o),
        .lcd_g_o     (lcd_g_o),
        .lcd_b_o     (lcd_b_o),
        .lcd_de_o    (lcd_de_o),
        .lcd_hsync_o (lcd_hsync_o),
        .lcd_vsync_o (lcd_vsync_o),
        .underrun_o  (underrun_o)
    );

endmodule

// ==== bench/tb_fb_display.sv ====
`timescale 1ns/1ps

module tb_fb_display import fb_pkg::*, lcd_pkg::*; ();

    localparam int CLK_PERIOD = 100;
    localparam int RST_CYCLES = 16;
    localparam int N_REWRITE = 4;
    localparam int TBL_LEN = 2 * FB_DEPTH + N_REWRITE;
    localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
    localparam int WATCHDOG_CYCLES = TBL_LEN * 20 + 3 * FRAME_CYCLES;

    logic clk245760 = 1'b0;
    logic rst;
    logic host_req_valid;
    logic host_req_we;
    fb_addr_t host_req_addr;
    fb_word_t host_req_wdata;
    logic host_req_ready_o;
    logic host_rdata_valid_o;
    fb_word_t host_rdata_o;
    color_t lcd_r_o;
    color_t lcd_g_o;
    color_t lcd_b_o;
    logic lcd_de_o;
    logic lcd_hsync_o;
    logic lcd_vsync_o;
    logic underrun_o;

    // stimulus table, one host request per entry
    logic tbl_we [TBL_LEN];
    fb_addr_t tbl_addr [TBL_LEN];
    fb_word_t tbl_data [TBL_LEN];

    fb_word_t model [FB_DEPTH];
    logic [31:0] lfsr = 32'hc3e9c6a4;
    logic mon_on = 1'b0;
    logic rd_pend = 1'b0;
    fb_word_t rd_exp;
    int checks = 0;
    int errors = 0;

    fb_display_top i_fb_display_top (
        .clk245760          (clk245760),
        .rst                (rst),
        .host_req_valid_i   (host_req_valid),
        .host_req_we_i      (host_req_we),
        .host_req_addr_i    (host_req_addr),
        .host_req_wdata_i   (host_req_wdata),
        .host_req_ready_o   (host_req_ready_o),
        .host_rdata_valid_o (host_rdata_valid_o),
        .host_rdata_o       (host_rdata_o),
        .lcd_r_o            (lcd_r_o),
        .lcd_g_o            (lcd_g_o),
        .lcd_b_o            (lcd_b_o),
        .lcd_de_o           (lcd_de_o),
        .lcd_hsync_o        (lcd_hsync_o),
        .lcd_vsync_o        (lcd_vsync_o),
        .underrun_o         (underrun_o)
    );

    always #(CLK_PERIOD / 2) clk245760 = ~clk245760;

    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    // one lfsr step per bit taken
    function automatic fb_word_t random_word();
        fb_word_t w;
        w = '0;
        for (int b = 0; b < $bits(fb_word_t); b++) begin
            lfsr = lfsr_next(lfsr);
            w = {w[$bits(fb_word_t)-2:0], lfsr[0]};
        end
        return w;
    endfunction

    task automatic check_word(fb_word_t got, fb_word_t exp, string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_color(color_t got, color_t exp, string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(logic got, logic exp, string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_count(int got, int exp, string what);
        checks++;
        if (got != exp) begin
            errors++;
            $display("[FAIL] %0t: %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    // outputs while the display logic is still held in reset
    task automatic check_quiet(logic mem_held);
        check_bit(lcd_de_o, 1'b0, "lcd_de in reset");
        check_bit(lcd_hsync_o, 1'b1, "hsync in reset");
        check_bit(lcd_vsync_o, 1'b1, "vsync in reset");
        check_bit(host_rdata_valid_o, 1'b0, "host rdata valid in reset");
        check_bit(underrun_o, 1'b0, "underrun in reset");
        if (mem_held) begin
            check_bit(host_req_ready_o, 1'b0, "host ready in memory reset");
        end
    endtask

    // writes everywhere, reads everywhere, then a few rewrites
    task automatic build_table();
        for (int i = 0; i < FB_DEPTH; i++) begin
            tbl_we[i] = 1'b1;
            tbl_addr[i] = fb_addr_t'(i);
            tbl_data[i] = random_word();
            tbl_we[FB_DEPTH + i] = 1'b0;
            tbl_addr[FB_DEPTH + i] = fb_addr_t'(i);
            tbl_data[FB_DEPTH + i] = '0;
        end
        // addresses 0 to 3 are prefetched before vsync, so they stay out
        for (int j = 0; j < N_REWRITE; j++) begin
            tbl_we[2 * FB_DEPTH + j] = 1'b1;
            tbl_addr[2 * FB_DEPTH + j] = fb_addr_t'(9 + 13 * j);
            tbl_data[2 * FB_DEPTH + j] = random_word();
        end
    endtask

    task automatic apply_table();
        @(posedge clk245760);
        for (int i = 0; i < TBL_LEN; i++) begin
            host_req_valid <= 1'b1;
            host_req_we <= tbl_we[i];
            host_req_addr <= tbl_addr[i];
            host_req_wdata <= tbl_data[i];
            @(negedge clk245760);
            while (!host_req_ready_o) begin
                @(negedge clk245760);
            end
            @(posedge clk245760);
        end
        host_req_valid <= 1'b0;
    endtask

    task automatic wait_vsync();
        logic prev;
        logic hit;
        prev = 1'b0;
        do begin
            @(negedge clk245760);
            hit = prev && !lcd_vsync_o;
            prev = lcd_vsync_o;
        end while (!hit);
    endtask

    // starts on the cycle vsync falls, ends on the next fall
    task automatic check_frame();
        int k;
        int hs;
        logic hs_prev;
        logic vs_prev;
        fb_word_t w;
        k = 0;
        hs = 0;
        hs_prev = lcd_hsync_o;
        do begin
            if (lcd_de_o) begin
                if (k < FB_DEPTH) begin
                    w = model[k];
                    check_color(lcd_r_o, w[17:12], "red");
                    check_color(lcd_g_o, w[11:6], "green");
                    check_color(lcd_b_o, w[5:0], "blue");
                end
                k++;
            end
            if (hs_prev && !lcd_hsync_o) begin
                hs++;
            end
            hs_prev = lcd_hsync_o;
            vs_prev = lcd_vsync_o;
            @(negedge clk245760);
        end while (!(vs_prev && !lcd_vsync_o));
        check_count(k, H_ACTIVE * V_ACTIVE, "active cycles per frame");
        check_count(hs, V_TOTAL, "hsync pulses per frame");
    endtask

    // host read return and model update, sampled away from the clock edge
    always @(negedge clk245760) begin
        if (mon_on) begin
            check_bit(underrun_o, 1'b0, "underrun");
            check_bit(host_rdata_valid_o, rd_pend, "host rdata valid");
            if (rd_pend) begin
                check_word(host_rdata_o, rd_exp, "host read data");
            end
            rd_pend = host_req_valid && host_req_ready_o && !host_req_we;
            if (rd_pend) begin
                rd_exp = model[host_req_addr];
            end
            if (host_req_valid && host_req_ready_o && host_req_we) begin
                model[host_req_addr] = host_req_wdata;
            end
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout: run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        rst = 1'b1;
        host_req_valid = 1'b0;
        host_req_we = 1'b0;
        host_req_addr = '0;
        host_req_wdata = '0;
        build_table();
        // first two edges settle the reset tree
        for (int i = 0; i < RST_CYCLES - 1; i++) begin
            @(negedge clk245760);
            if (i > 1) begin
                check_quiet(1'b1);
            end
        end
        @(posedge clk245760);
        rst <= 1'b0;
        mon_on <= 1'b1;
        for (int i = 0; i < CORE_RST_CYCLES; i++) begin
            @(negedge clk245760);
            check_quiet(i < MEM_RST_CYCLES);
        end
        apply_table();
        wait_vsync();
        check_frame();
        check_frame();
        $display("checks run %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
logic/fb_pkg.sv
logic/lcd_pkg.sv
logic/rst_seq.sv
logic/fb_mem.sv
logic/fb_arbiter.sv
logic/fb_fetch.sv
logic/lcd_timing.sv
logic/fb_display_top.sv
bench/tb_fb_display.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= tb_fb_display
FILELIST ?= tb.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing -Wno-fatal
PASS_TEXT ?= ALL CHECKS PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_TEXT)$$"

clean:
	rm -rf $(OBJ_DIR)
